// File: design/mul88_pkg.sv
// ====================================================================
// widths and vector types shared by the 88x88 multiply unit
// operands are 88 bits and the product is the full 176 bits
// the Karatsuba split is fixed at two levels (44 then 22 bits)
// ====================================================================
`default_nettype none

package mul88_pkg;

  // ==================================================================
  // widths
  // ==================================================================

  // one operand as seen at the unit boundary
  localparam int operand_w = 88;

  // first Karatsuba split of an operand
  localparam int half_w = operand_w / 2;

  // second Karatsuba split, used inside the 44x44 block only
  localparam int quarter_w = half_w / 2;

  // full double width product, nothing is truncated
  localparam int product_w = 2 * operand_w;

  // ==================================================================
  // types
  // ==================================================================

  // an operand, or the magnitude of a signed operand
  typedef logic [operand_w-1:0] operand_t;

  // one Karatsuba half of an operand
  typedef logic [half_w-1:0] half_t;

  // product of two halves, as returned by the 44x44 block
  typedef logic [2*half_w-1:0] half_product_t;

  // the complete 88x88 result
  typedef logic [product_w-1:0] product_t;

endpackage

`default_nettype wire

// File: design/mul_stage_if.sv
// ====================================================================
// request bundle between the operand stage and the product stage
// plain strobe protocol with no acknowledge, so the sink must take
// the request in the cycle that valid is high
// ====================================================================
`default_nettype none

interface mul_stage_if;
  import mul88_pkg::*;

  // one cycle strobe marking a request in flight
  logic valid;

  // unsigned magnitudes of the two operands
  operand_t a_mag;
  operand_t b_mag;

  // set when the magnitude product has to be negated
  logic neg;

  // the operand stage owns every signal and drives them from flops
  modport source (
    output valid,
    output a_mag,
    output b_mag,
    output neg
  );

  // the product stage only looks at the request
  modport sink (
    input valid,
    input a_mag,
    input b_mag,
    input neg
  );

endinterface

`default_nettype wire

// File: design/mult44x44comb.sv
// ====================================================================
// combinational 44x44 unsigned multiplier with one Karatsuba level
// inputs are treated as unsigned, the result is the exact 88 bits
// no pipelining here, timing closure is left to the enclosing stage
// ====================================================================
`default_nettype none

module mult44x44comb (
  input  mul88_pkg::half_t         a,
  input  mul88_pkg::half_t         b,
  output mul88_pkg::half_product_t o
);
  import mul88_pkg::*;

  // differences of the 22-bit halves, one extra bit holds the borrow
  logic [quarter_w:0]   a_dif;
  logic [quarter_w:0]   b_dif;
  logic [quarter_w-1:0] a_abs;
  logic [quarter_w-1:0] b_abs;
  logic                 dif_neg;

  // three 22x22 sub-products
  logic [half_w-1:0]    z2;
  logic [half_w-1:0]    z0;
  logic [half_w-1:0]    p3;

  // signed middle correction and the middle term itself
  // two guard bits cover the sign and the carry out of the sum
  logic [half_w+1:0]    p4;
  logic [half_w+1:0]    z1;

  // x0 - x1 for a and y1 - y0 for b, so that the middle term becomes
  // z2 + z0 + (x0-x1)*(y1-y0) which equals x1*y0 + x0*y1
  assign a_dif = {1'b0, a[quarter_w-1:0]} - {1'b0, a[half_w-1:quarter_w]};
  assign b_dif = {1'b0, b[half_w-1:quarter_w]} - {1'b0, b[quarter_w-1:0]};

  // magnitudes of the differences always fit in 22 bits
  assign a_abs = a_dif[quarter_w] ? quarter_w'(-a_dif) : quarter_w'(a_dif);
  assign b_abs = b_dif[quarter_w] ? quarter_w'(-b_dif) : quarter_w'(b_dif);

  // sign of the difference product
  assign dif_neg = a_dif[quarter_w] ^ b_dif[quarter_w];

  // high halves, low halves and difference magnitudes
  assign z2 = a[half_w-1:quarter_w] * b[half_w-1:quarter_w];
  assign z0 = a[quarter_w-1:0] * b[quarter_w-1:0];
  assign p3 = a_abs * b_abs;

  // reapply the sign of the difference product in 46-bit two's complement
  assign p4 = dif_neg ? -{2'b00, p3} : {2'b00, p3};

  // the true middle term is never negative and stays below 2**45,
  // so the wrap of the 46-bit sum still leaves the exact value
  assign z1 = p4 + {2'b00, z2} + {2'b00, z0};

  // high and low products sit side by side, the middle term lands
  // one quarter width up
  assign o = {z2, z0} + (half_product_t'(z1) << quarter_w);

endmodule

`default_nettype wire

// File: design/mult88x88comb.sv
// ====================================================================
// combinational 88x88 unsigned Karatsuba multiplier
// built from three 44x44 blocks, result is the full 176 bits
// purely combinational, the caller registers the output
// ====================================================================
`default_nettype none

module mult88x88comb (
  input  mul88_pkg::operand_t a,
  input  mul88_pkg::operand_t b,
  output mul88_pkg::product_t o
);
  import mul88_pkg::*;

  // ==================================================================
  // half differences
  // ==================================================================

  // 45-bit differences, the top bit is the borrow and so the sign
  logic [half_w:0] a_dif;
  logic [half_w:0] b_dif;
  half_t           a_abs;
  half_t           b_abs;
  logic            dif_neg;

  // low minus high for a, high minus low for b
  assign a_dif = {1'b0, a[half_w-1:0]} - {1'b0, a[operand_w-1:half_w]};
  assign b_dif = {1'b0, b[operand_w-1:half_w]} - {1'b0, b[half_w-1:0]};

  // even the largest borrow case has a magnitude that fits in 44 bits
  assign a_abs = a_dif[half_w] ? half_t'(-a_dif) : half_t'(a_dif);
  assign b_abs = b_dif[half_w] ? half_t'(-b_dif) : half_t'(b_dif);

  // the difference product is negative when exactly one side borrowed
  assign dif_neg = a_dif[half_w] ^ b_dif[half_w];

  // ==================================================================
  // three sub-products
  // ==================================================================

  half_product_t z2;
  half_product_t z0;
  half_product_t p3;

  // z2 is the product of the high halves
  mult44x44comb u_mul_hi (
    .a (a[operand_w-1:half_w]),
    .b (b[operand_w-1:half_w]),
    .o (z2)
  );

  // z0 is the product of the low halves
  mult44x44comb u_mul_lo (
    .a (a[half_w-1:0]),
    .b (b[half_w-1:0]),
    .o (z0)
  );

  // p3 is the product of the difference magnitudes
  mult44x44comb u_mul_mid (
    .a (a_abs),
    .b (b_abs),
    .o (p3)
  );

  // ==================================================================
  // recombination
  // ==================================================================

  // signed difference product and the middle term, 89 bits each
  // the extra bit is the carry of the middle term
  logic [operand_w:0] p4;
  logic [operand_w:0] z1;

  assign p4 = dif_neg ? -{1'b0, p3} : {1'b0, p3};

  // x1*y0 + x0*y1 is below 2**89, so dropping the bits above 89 is exact
  assign z1 = p4 + {1'b0, z2} + {1'b0, z0};

  // z2 in the top half, z0 in the bottom half, z1 shifted up by 44
  assign o = {z2, z0} + (product_t'(z1) << half_w);

endmodule

`default_nettype wire

// File: design/mul_operand_stage.sv
// ====================================================================
// first pipeline stage of the multiply unit
// a request is captured only on a start pulse, one per cycle at most
// signed operands leave this stage as magnitudes plus a negate flag
// ====================================================================
`default_nettype none

module mul_operand_stage (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                start,
  input  logic                is_signed,
  input  mul88_pkg::operand_t a,
  input  mul88_pkg::operand_t b,
  mul_stage_if.source         req
);
  import mul88_pkg::*;

  // ==================================================================
  // sign handling
  // ==================================================================

  // operand sign bits count only for a signed request
  logic     a_sgn;
  logic     b_sgn;
  operand_t a_abs;
  operand_t b_abs;

  assign a_sgn = is_signed & a[operand_w-1];
  assign b_sgn = is_signed & b[operand_w-1];

  // two's complement absolute value
  // the most negative input comes out as 2**87, which is still a valid
  // unsigned 88-bit magnitude
  assign a_abs = a_sgn ? -a : a;
  assign b_abs = b_sgn ? -b : b;

  // ==================================================================
  // request registers
  // ==================================================================

  // valid follows start one edge later and is the only control flop
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      req.valid <= 1'b0;
    end else begin
      req.valid <= start;
    end
  end

  // operand data only moves on a start, it is ignored while valid is low
  always_ff @(posedge clk) begin
    if (start) begin
      req.a_mag <= a_abs;
      req.b_mag <= b_abs;
      // product is negative when the operand signs differ
      req.neg   <= a_sgn ^ b_sgn;
    end
  end

endmodule

`default_nettype wire

// File: design/mul_product_stage.sv
// ====================================================================
// second pipeline stage of the multiply unit
// the full 88x88 multiply sits in this single cycle with no retiming
// prod holds the last result until the next done pulse
// ====================================================================
`default_nettype none

module mul_product_stage (
  input  logic                clk,
  input  logic                arst_n,
  mul_stage_if.sink           req,
  output mul88_pkg::product_t prod,
  output logic                done
);
  import mul88_pkg::*;

  // ==================================================================
  // multiply and sign
  // ==================================================================

  // unsigned product of the two magnitudes
  product_t mag_prod;

  // final product after the sign has been applied
  product_t res_prod;

  mult88x88comb u_mult (
    .a (req.a_mag),
    .b (req.b_mag),
    .o (mag_prod)
  );

  // 176-bit two's complement negate when the request asks for it
  // a zero magnitude product stays zero either way
  assign res_prod = req.neg ? -mag_prod : mag_prod;

  // ==================================================================
  // output registers
  // ==================================================================

  // done is a one cycle pulse that tracks the request strobe,
  // and back to back requests give back to back dones
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prod <= '0;
      done <= 1'b0;
    end else begin
      done <= req.valid;
      if (req.valid) begin
        prod <= res_prod;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/mul88_unit.sv
// ====================================================================
// 88x88 integer multiply unit, signed or unsigned per request
// done rises two clock edges after start and cannot be stalled
// the consumer must take every done in the cycle it appears
// ====================================================================
`default_nettype none

module mul88_unit (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                start,
  input  logic                is_signed,
  input  mul88_pkg::operand_t a,
  input  mul88_pkg::operand_t b,
  output mul88_pkg::product_t prod,
  output logic                done
);

  // one request in flight between the two stages
  mul_stage_if u_req ();

  // edge one, capture the request and strip the signs
  mul_operand_stage u_operand_stage (
    .clk       (clk),
    .arst_n    (arst_n),
    .start     (start),
    .is_signed (is_signed),
    .a         (a),
    .b         (b),
    .req       (u_req)
  );

  // edge two, multiply, restore the sign and register the result
  mul_product_stage u_product_stage (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (u_req),
    .prod   (prod),
    .done   (done)
  );

endmodule

`default_nettype wire

// File: bench/tb_mul88_unit.sv
// ====================================================================
// the 88x88 multiply unit testbench expects to run from the project root
// vectors come from bench/mul88_stimulus.txt plus seeded random ones
// inputs change on the rising edge and outputs are sampled on the falling one
// ====================================================================
`default_nettype none

module tb_mul88_unit;
  timeunit 1ns;
  timeprecision 1ps;

  import mul88_pkg::*;

  localparam int clk_period   = 40;
  localparam int reset_cycles = 10;
  localparam int random_count = 24;

  logic     clk = 1'b0;
  logic     arst_n;
  logic     start;
  logic     is_signed;
  operand_t a;
  operand_t b;
  product_t prod;
  logic     done;

  // vector table with the file entries first and the random entries after them
  string    v_name[$];
  int       v_gap[$];
  bit       v_sgn[$];
  operand_t v_a[$];
  operand_t v_b[$];
  product_t v_exp[$];

  // requests in flight with the oldest one at the front
  product_t exp_q[$];
  string    name_q[$];

  bit       load_ok;
  bit       vectors_ready;
  bit [1:0] start_pipe;
  bit       seen_done;
  // value prod must show while no done is present
  product_t held_prod = '0;
  int       tests_passed;
  int       tests_failed;
  int       other_errors;
  int       max_gap;
  int       seed;

  mul88_unit u_mul88_unit (
    .clk       (clk),
    .arst_n    (arst_n),
    .start     (start),
    .is_signed (is_signed),
    .a         (a),
    .b         (b),
    .prod      (prod),
    .done      (done)
  );

  always #(clk_period/2) clk = ~clk;

  // ==================================================================
  // vector setup
  // ==================================================================

  task automatic load_vectors();
    int       fd;
    int       n;
    int       gap;
    int       sgn;
    string    line;
    string    nm;
    operand_t av;
    operand_t bv;
    product_t ev;
    fd = $fopen("bench/mul88_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file bench/mul88_stimulus.txt");
      load_ok = 1'b0;
    end else begin
      load_ok = 1'b1;
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        // blank lines and lines that start with # (8'h23) hold no vector
        if (n > 1 && line.getc(0) != 8'h23) begin
          n = $sscanf(line, "%s %d %d %h %h %h", nm, gap, sgn, av, bv, ev);
          if (n == 6) begin
            v_name.push_back(nm);
            v_gap.push_back(gap);
            v_sgn.push_back(sgn != 0);
            v_a.push_back(av);
            v_b.push_back(bv);
            v_exp.push_back(ev);
          end else begin
            $display("stimulus line could not be parsed: %s", line);
            load_ok = 1'b0;
          end
        end
      end
      $fclose(fd);
      if (v_exp.size() == 0) begin
        $display("the stimulus file holds no vectors");
        load_ok = 1'b0;
      end
    end
  endtask

  // unsigned random operands checked against a plain 176-bit multiply
  task automatic add_random_vectors();
    logic [95:0] r_a;
    logic [95:0] r_b;
    seed = 79;
    for (int i = 0; i < random_count; i++) begin
      r_a = {$random(seed), $random(seed), $random(seed)};
      r_b = {$random(seed), $random(seed), $random(seed)};
      v_name.push_back($sformatf("rand_%0d", i));
      // mostly back to back starts with a short pause now and then
      v_gap.push_back((i % 8 == 7) ? 2 : 0);
      v_sgn.push_back(1'b0);
      v_a.push_back(r_a[operand_w-1:0]);
      v_b.push_back(r_b[operand_w-1:0]);
      v_exp.push_back(product_t'(r_a[operand_w-1:0]) * product_t'(r_b[operand_w-1:0]));
    end
  endtask

  // ==================================================================
  // compare tasks
  // ==================================================================

  task automatic check_product(input string name, input product_t expected,
                               input product_t actual, output bit ok);
    ok = (expected == actual);
    if (!ok) begin
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic check_done(input string name, input bit expected,
                            input bit actual, output bit ok);
    ok = (expected == actual);
    if (!ok) begin
      $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
    end
  endtask

  // ==================================================================
  // drivers
  // ==================================================================

  // junk on the operand pins while idle that the unit must not pick up
  task automatic drive_idle();
    start     <= 1'b0;
    is_signed <= 1'b1;
    a         <= '1;
    b         <= '1;
  endtask

  // one start pulse, then the idle gap that the vector asks for
  task automatic issue_request(input int idx);
    @(posedge clk);
    start     <= 1'b1;
    is_signed <= v_sgn[idx];
    a         <= v_a[idx];
    b         <= v_b[idx];
    exp_q.push_back(v_exp[idx]);
    name_q.push_back(v_name[idx]);
    repeat (v_gap[idx]) begin
      @(posedge clk);
      drive_idle();
    end
  endtask

  // ==================================================================
  // result monitor
  // ==================================================================

  always @(negedge clk) begin
    bit       ok;
    string    nm;
    product_t ev;
    // a start seen two falling edges ago must show up as done now
    check_done("done_timing", start_pipe[1], done, ok);
    if (!ok) other_errors++;
    if (done) begin
      seen_done = 1'b1;
      if (exp_q.size() == 0) begin
        $display("done pulsed while no request was outstanding");
        other_errors++;
      end else begin
        ev = exp_q.pop_front();
        nm = name_q.pop_front();
        held_prod = ev;
        check_product(nm, ev, prod, ok);
        if (ok) begin
          $display("pass %s", nm);
          tests_passed++;
        end else begin
          tests_failed++;
        end
      end
    end else if (!seen_done) begin
      // prod keeps its reset value until the first result lands
      check_product("prod_idle", held_prod, prod, ok);
      if (!ok) other_errors++;
    end else begin
      // between two dones prod still shows the last result
      check_product("prod_hold", held_prod, prod, ok);
      if (!ok) other_errors++;
    end
    start_pipe = {start_pipe[0], start};
  end

  // ==================================================================
  // main sequence and watchdog
  // ==================================================================

  initial begin
    arst_n    = 1'b0;
    start     = 1'b0;
    is_signed = 1'b0;
    a         = '0;
    b         = '0;
    load_vectors();
    if (load_ok) begin
      add_random_vectors();
      max_gap = 0;
      foreach (v_gap[i]) begin
        if (v_gap[i] > max_gap) max_gap = v_gap[i];
      end
      vectors_ready = 1'b1;
      repeat (reset_cycles) @(posedge clk);
      arst_n <= 1'b1;
      for (int i = 0; i < v_exp.size(); i++) begin
        issue_request(i);
      end
      @(posedge clk);
      drive_idle();
      while (exp_q.size() != 0) @(negedge clk);
      // quiet cycles to catch a stray done after the last result
      repeat (4) @(negedge clk);
      // the monitor has finished its last falling edge by the next rising one
      @(posedge clk);
    end
    $display("tests passed %0d, failed %0d, other errors %0d",
             tests_passed, tests_failed, other_errors);
    if (load_ok && tests_failed == 0 && other_errors == 0 && tests_passed == v_exp.size()) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // the limit grows with the vector count and the longest idle gap
  initial begin
    int wd_cycles;
    wait (vectors_ready);
    wd_cycles = v_exp.size() * (max_gap + 4) + reset_cycles;
    #(wd_cycles * clk_period);
    $display("watchdog timeout after %0d cycles, %0d results still outstanding",
             wd_cycles, exp_q.size());
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/mul88_stimulus.txt
# name gap is_signed a b expected, with a, b and expected in hex without leading zeros
# gap counts idle cycles after the start, is_signed is 0 or 1
zero_a 0 0 0 FFFFFFFFFFFFFFFFFFFFFF 0
one_a 1 0 1 FFFFFFFFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFFFFFFFF
ones_u 0 0 FFFFFFFFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFFFFFFFE0000000000000000000001
ones_x2 2 0 FFFFFFFFFFFFFFFFFFFFFF 2 1FFFFFFFFFFFFFFFFFFFFFE
kar_pp 0 0 100000000003 500000000002 50000000001100000000006
kar_nn 0 0 300000000001 200000000005 60000000001100000000005
kar_pn 0 0 100000000003 200000000005 20000000000B0000000000F
kar_np 3 0 300000000001 500000000002 F0000000000B00000000002
eq_half 0 0 100000000001 100000000001 10000000000200000000001
min_u_x2 0 0 8000000000000000000000 2 10000000000000000000000
s_m1_m1 1 1 FFFFFFFFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFFFFFFFF 1
s_m1_p1 0 1 FFFFFFFFFFFFFFFFFFFFFF 1 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
s_mn_mn 0 1 8000000000000000000000 8000000000000000000000 40000000000000000000000000000000000000000000
s_mn_m1 0 1 8000000000000000000000 FFFFFFFFFFFFFFFFFFFFFF 8000000000000000000000
s_mn_p1 2 1 8000000000000000000000 1 FFFFFFFFFFFFFFFFFFFFFF8000000000000000000000
s_m3_p5 0 1 FFFFFFFFFFFFFFFFFFFFFD 5 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF1
s_p7_m2 0 1 7 FFFFFFFFFFFFFFFFFFFFFE FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF2
s_m3_m5 0 1 FFFFFFFFFFFFFFFFFFFFFD FFFFFFFFFFFFFFFFFFFFFB F
s_mh_p 1 1 FFFFFFFFFFF00000000000 100000000001 FFFFFFFFFFFFFFFFFFFFFEFFFFFFFFFFF00000000000
s_pos 0 1 6 7 2A
s_zero 0 1 0 FFFFFFFFFFFFFFFFFFFFFF 0
u_ones_p1 5 0 FFFFFFFFFFFFFFFFFFFFFF 1 FFFFFFFFFFFFFFFFFFFFFF

// File: list.f
design/mul88_pkg.sv
design/mul_stage_if.sv
design/mult44x44comb.sv
design/mult88x88comb.sv
design/mul_operand_stage.sv
design/mul_product_stage.sv
design/mul88_unit.sv
bench/tb_mul88_unit.sv

// File: run.sh
#!/usr/bin/env bash
# builds the multiply unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_mul88_unit -f list.f -o sim_tb
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/sim_tb 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "Result: PASSED"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
